//--- common/byp_consts.svh
// Bypass controller constants
// Read port count and address widths shared by the packages and the RTL
`ifndef BYP_CONSTS_SVH
`define BYP_CONSTS_SVH

//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

// Number of register file read ports decoded in ID
`define BYP_NUM_READ_PORTS 2

// Register file address width, 32 architectural registers
`define BYP_REG_ADDR_W 5

//////////////////////////////////////////////////
// CSR file
//////////////////////////////////////////////////

// CSR address width as defined by the privileged spec
`define BYP_CSR_ADDR_W 12

`endif

//--- common/byp_pipe_pkg.sv
// Pipeline types for the bypass controller
// Register address type and the forwarding mux select encodings
`default_nettype none

`include "byp_consts.svh"

package byp_pipe_pkg;

  // Register file address as seen in every pipeline stage
  typedef logic [`BYP_REG_ADDR_W-1:0] reg_addr_t;

  // Source of an ID operand
  // SEL_FW_EX takes the EX result, SEL_FW_WB the WB write data
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_sel_e;

  // Source of the jump register target
  // Only WB can forward here, and only for ALU results
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage

`default_nettype wire

//--- common/byp_csr_pkg.sv
// CSR types for the bypass controller
// Holds the CSR address type used by the hazard check
`default_nettype none

`include "byp_consts.svh"

package byp_csr_pkg;

  // CSR address, read in EX and written in WB
  typedef logic [`BYP_CSR_ADDR_W-1:0] csr_addr_t;

endpackage

`default_nettype wire

//--- bypass/operand_hazard_unit.sv
// Operand hazard unit
// Matches ID read addresses against EX and WB writes, picks forwarding
// sources for both operands and the jalr path, and flags load and jalr stalls
`timescale 1ns/1ps
`default_nettype none

`include "byp_consts.svh"

module operand_hazard_unit (
  input  wire logic                            id_valid_i,
  input  wire logic [`BYP_NUM_READ_PORTS-1:0]  rf_re_id_i,
  input  wire byp_pipe_pkg::reg_addr_t         rf_raddr_a_id_i,
  input  wire byp_pipe_pkg::reg_addr_t         rf_raddr_b_id_i,
  input  wire logic                            jalr_id_i,
  input  wire logic                            ex_valid_i,
  input  wire logic                            ex_rf_we_i,
  input  wire byp_pipe_pkg::reg_addr_t         ex_rf_waddr_i,
  input  wire logic                            ex_lsu_en_i,
  input  wire logic                            wb_valid_i,
  input  wire logic                            wb_rf_we_i,
  input  wire byp_pipe_pkg::reg_addr_t         wb_rf_waddr_i,
  input  wire logic                            wb_lsu_en_i,
  input  wire logic                            wb_ready_i,
  output byp_pipe_pkg::op_fw_sel_e             op_a_sel_o,
  output byp_pipe_pkg::op_fw_sel_e             op_b_sel_o,
  output byp_pipe_pkg::jalr_fw_sel_e           jalr_sel_o,
  output logic                                 load_stall_o,
  output logic                                 jalr_stall_o
);

  // Read addresses gathered per port, index 0 is rs1
  byp_pipe_pkg::reg_addr_t         rf_raddr_id [`BYP_NUM_READ_PORTS];
  logic [`BYP_NUM_READ_PORTS-1:0]  ex_match;
  logic [`BYP_NUM_READ_PORTS-1:0]  wb_match;
  logic                            ex_we;
  logic                            wb_we;
  logic                            wb_load;
  logic                            ex_jalr_match;
  logic                            wb_jalr_match;

  // Stage writes only count while the stage holds a valid instruction
  assign ex_we   = ex_valid_i && ex_rf_we_i;
  assign wb_we   = wb_valid_i && wb_rf_we_i;
  assign wb_load = wb_we && wb_lsu_en_i;

  assign rf_raddr_id[0] = rf_raddr_a_id_i;
  assign rf_raddr_id[1] = rf_raddr_b_id_i;

  //////////////////////////////////////////////////
  // Address matching
  //////////////////////////////////////////////////

  // A port matches when it reads a nonzero register that a stage writes
  // Reads of x0 always return zero, so x0 never forwards
  for (genvar i = 0; i < `BYP_NUM_READ_PORTS; i++) begin : gen_port_match
    assign ex_match[i] = id_valid_i && rf_re_id_i[i] && (|rf_raddr_id[i]) &&
                         ex_we && (rf_raddr_id[i] == ex_rf_waddr_i);
    assign wb_match[i] = id_valid_i && rf_re_id_i[i] && (|rf_raddr_id[i]) &&
                         wb_we && (rf_raddr_id[i] == wb_rf_waddr_i);
  end

  // jalr reads rs1 implicitly, so the read enable is not needed here
  assign ex_jalr_match = ex_we && (|rf_raddr_id[0]) && (rf_raddr_id[0] == ex_rf_waddr_i);
  assign wb_jalr_match = wb_we && (|rf_raddr_id[0]) && (rf_raddr_id[0] == wb_rf_waddr_i);

  //////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////

  always_comb begin
    op_a_sel_o = byp_pipe_pkg::SEL_REGFILE;
    op_b_sel_o = byp_pipe_pkg::SEL_REGFILE;
    // WB first so that a younger EX result overrides it
    if (wb_match[0]) begin
      op_a_sel_o = byp_pipe_pkg::SEL_FW_WB;
    end
    if (wb_match[1]) begin
      op_b_sel_o = byp_pipe_pkg::SEL_FW_WB;
    end
    if (ex_match[0]) begin
      op_a_sel_o = byp_pipe_pkg::SEL_FW_EX;
    end
    if (ex_match[1]) begin
      op_b_sel_o = byp_pipe_pkg::SEL_FW_EX;
    end
  end

  // WB forwarding to the jump target, a WB load stalls instead (see below)
  assign jalr_sel_o = wb_jalr_match ? byp_pipe_pkg::SELJ_FW_WB : byp_pipe_pkg::SELJ_REGFILE;

  //////////////////////////////////////////////////
  // Stalls
  //////////////////////////////////////////////////

  // Load data is not there yet while the load sits in EX or WB waits on memory
  assign load_stall_o = (ex_lsu_en_i && |ex_match) || (!wb_ready_i && |wb_match);

  // The jump target path has no EX forward and no load forward from WB
  assign jalr_stall_o = id_valid_i && jalr_id_i &&
                        (ex_jalr_match || (wb_jalr_match && wb_load));

endmodule

`default_nettype wire

//--- bypass/csr_hazard_unit.sv
// CSR hazard unit
// Detects implicit and explicit CSR read-after-write hazards between
// ID, EX and WB and flags the sleep stall for WFI in EX
`timescale 1ns/1ps
`default_nettype none

module csr_hazard_unit (
  input  wire logic                    id_valid_i,
  input  wire logic                    mret_id_i,
  input  wire logic                    ex_valid_i,
  input  wire logic                    ex_csr_en_i,
  input  wire logic                    ex_mret_i,
  input  wire logic                    ex_wfi_i,
  input  wire logic                    wb_valid_i,
  input  wire logic                    wb_csr_en_i,
  input  wire logic                    wb_mret_i,
  input  wire logic                    csr_re_ex_i,
  input  wire byp_csr_pkg::csr_addr_t  csr_raddr_ex_i,
  input  wire logic                    csr_we_wb_i,
  input  wire byp_csr_pkg::csr_addr_t  csr_waddr_wb_i,
  output logic                         csr_stall_id_o,
  output logic                         csr_stall_ex_o,
  output logic                         sleep_stall_o
);

  logic csr_write_ex;
  logic csr_write_wb;
  logic impl_write_wb;
  logic expl_hz_ex;

  // mret updates mstatus and friends, so it counts as an implicit write
  assign csr_write_ex  = ex_valid_i && (ex_csr_en_i || ex_mret_i);
  assign csr_write_wb  = wb_valid_i && (wb_csr_en_i || wb_mret_i);
  assign impl_write_wb = wb_valid_i && wb_mret_i;

  // Precise check, explicit read in EX hits the CSR being written in WB
  assign expl_hz_ex = ex_valid_i && csr_re_ex_i &&
                      wb_valid_i && csr_we_wb_i &&
                      (csr_raddr_ex_i == csr_waddr_wb_i);

  //////////////////////////////////////////////////
  // Stall decisions
  //////////////////////////////////////////////////

  // mret reads mepc in ID, so hold it behind any CSR write still in flight
  // This is conservative, the written address is not looked at
  assign csr_stall_id_o = id_valid_i && mret_id_i && (csr_write_ex || csr_write_wb);

  // An implicit write in WB may touch any CSR, so every CSR op in EX waits
  assign csr_stall_ex_o = expl_hz_ex || (ex_valid_i && ex_csr_en_i && impl_write_wb);

  // Keep loads and stores out of EX while WFI may put the core to sleep
  assign sleep_stall_o = ex_valid_i && ex_wfi_i;

endmodule

`default_nettype wire

//--- bypass/stall_merge.sv
// Stall merger
// Registers the forwarding selects and hazard flags and folds them
// into one ID stall and one EX stall
`timescale 1ns/1ps
`default_nettype none

module stall_merge (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  input  wire byp_pipe_pkg::op_fw_sel_e    op_a_sel_i,
  input  wire byp_pipe_pkg::op_fw_sel_e    op_b_sel_i,
  input  wire byp_pipe_pkg::jalr_fw_sel_e  jalr_sel_i,
  input  wire logic                        load_stall_i,
  input  wire logic                        jalr_stall_i,
  input  wire logic                        csr_stall_id_i,
  input  wire logic                        csr_stall_ex_i,
  input  wire logic                        sleep_stall_i,
  output byp_pipe_pkg::op_fw_sel_e         op_a_sel_o,
  output byp_pipe_pkg::op_fw_sel_e         op_b_sel_o,
  output byp_pipe_pkg::jalr_fw_sel_e       jalr_sel_o,
  output logic                             load_stall_o,
  output logic                             jalr_stall_o,
  output logic                             csr_stall_id_o,
  output logic                             csr_stall_ex_o,
  output logic                             sleep_stall_o,
  output logic                             stall_id_o,
  output logic                             stall_ex_o
);

  logic stall_ex_d;
  logic stall_id_d;

  // Only the CSR hazard holds EX
  assign stall_ex_d = csr_stall_ex_i;

  // A stalled EX cannot accept the ID instruction, so ID stalls too
  assign stall_id_d = load_stall_i || jalr_stall_i || csr_stall_id_i ||
                      sleep_stall_i || stall_ex_d;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_a_sel_o     <= byp_pipe_pkg::SEL_REGFILE;
      op_b_sel_o     <= byp_pipe_pkg::SEL_REGFILE;
      jalr_sel_o     <= byp_pipe_pkg::SELJ_REGFILE;
      load_stall_o   <= 1'b0;
      jalr_stall_o   <= 1'b0;
      csr_stall_id_o <= 1'b0;
      csr_stall_ex_o <= 1'b0;
      sleep_stall_o  <= 1'b0;
      stall_id_o     <= 1'b0;
      stall_ex_o     <= 1'b0;
    end else begin
      op_a_sel_o     <= op_a_sel_i;
      op_b_sel_o     <= op_b_sel_i;
      jalr_sel_o     <= jalr_sel_i;
      load_stall_o   <= load_stall_i;
      jalr_stall_o   <= jalr_stall_i;
      csr_stall_id_o <= csr_stall_id_i;
      csr_stall_ex_o <= csr_stall_ex_i;
      sleep_stall_o  <= sleep_stall_i;
      stall_id_o     <= stall_id_d;
      stall_ex_o     <= stall_ex_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/bypass_ctrl.sv
// Bypass and hazard controller top level
// Runs the operand and CSR hazard units in parallel and registers
// their results through the stall merger, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

`include "byp_consts.svh"

module bypass_ctrl (
  input  wire logic                            clk,
  input  wire logic                            rst_n_i,
  // ID stage
  input  wire logic                            id_valid_i,
  input  wire logic [`BYP_NUM_READ_PORTS-1:0]  rf_re_id_i,
  input  wire byp_pipe_pkg::reg_addr_t         rf_raddr_a_id_i,
  input  wire byp_pipe_pkg::reg_addr_t         rf_raddr_b_id_i,
  input  wire logic                            jalr_id_i,
  input  wire logic                            mret_id_i,
  // EX stage
  input  wire logic                            ex_valid_i,
  input  wire logic                            ex_rf_we_i,
  input  wire byp_pipe_pkg::reg_addr_t         ex_rf_waddr_i,
  input  wire logic                            ex_lsu_en_i,
  input  wire logic                            ex_csr_en_i,
  input  wire logic                            ex_mret_i,
  input  wire logic                            ex_wfi_i,
  // WB stage
  input  wire logic                            wb_valid_i,
  input  wire logic                            wb_rf_we_i,
  input  wire byp_pipe_pkg::reg_addr_t         wb_rf_waddr_i,
  input  wire logic                            wb_lsu_en_i,
  input  wire logic                            wb_csr_en_i,
  input  wire logic                            wb_mret_i,
  input  wire logic                            wb_ready_i,
  // CSR file
  input  wire logic                            csr_re_ex_i,
  input  wire byp_csr_pkg::csr_addr_t          csr_raddr_ex_i,
  input  wire logic                            csr_we_wb_i,
  input  wire byp_csr_pkg::csr_addr_t          csr_waddr_wb_i,
  // Registered controls
  output byp_pipe_pkg::op_fw_sel_e             op_a_sel_o,
  output byp_pipe_pkg::op_fw_sel_e             op_b_sel_o,
  output byp_pipe_pkg::jalr_fw_sel_e           jalr_sel_o,
  output logic                                 load_stall_o,
  output logic                                 jalr_stall_o,
  output logic                                 csr_stall_id_o,
  output logic                                 csr_stall_ex_o,
  output logic                                 sleep_stall_o,
  output logic                                 stall_id_o,
  output logic                                 stall_ex_o
);

  // Combinational hazard results, before the output register
  byp_pipe_pkg::op_fw_sel_e    op_a_sel;
  byp_pipe_pkg::op_fw_sel_e    op_b_sel;
  byp_pipe_pkg::jalr_fw_sel_e  jalr_sel;
  logic                        load_stall;
  logic                        jalr_stall;
  logic                        csr_stall_id;
  logic                        csr_stall_ex;
  logic                        sleep_stall;

  //////////////////////////////////////////////////
  // Hazard units
  //////////////////////////////////////////////////

  operand_hazard_unit u_operand_hz (
    .id_valid_i      (id_valid_i),
    .rf_re_id_i      (rf_re_id_i),
    .rf_raddr_a_id_i (rf_raddr_a_id_i),
    .rf_raddr_b_id_i (rf_raddr_b_id_i),
    .jalr_id_i       (jalr_id_i),
    .ex_valid_i      (ex_valid_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .ex_lsu_en_i     (ex_lsu_en_i),
    .wb_valid_i      (wb_valid_i),
    .wb_rf_we_i      (wb_rf_we_i),
    .wb_rf_waddr_i   (wb_rf_waddr_i),
    .wb_lsu_en_i     (wb_lsu_en_i),
    .wb_ready_i      (wb_ready_i),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .jalr_sel_o      (jalr_sel),
    .load_stall_o    (load_stall),
    .jalr_stall_o    (jalr_stall)
  );

  csr_hazard_unit u_csr_hz (
    .id_valid_i     (id_valid_i),
    .mret_id_i      (mret_id_i),
    .ex_valid_i     (ex_valid_i),
    .ex_csr_en_i    (ex_csr_en_i),
    .ex_mret_i      (ex_mret_i),
    .ex_wfi_i       (ex_wfi_i),
    .wb_valid_i     (wb_valid_i),
    .wb_csr_en_i    (wb_csr_en_i),
    .wb_mret_i      (wb_mret_i),
    .csr_re_ex_i    (csr_re_ex_i),
    .csr_raddr_ex_i (csr_raddr_ex_i),
    .csr_we_wb_i    (csr_we_wb_i),
    .csr_waddr_wb_i (csr_waddr_wb_i),
    .csr_stall_id_o (csr_stall_id),
    .csr_stall_ex_o (csr_stall_ex),
    .sleep_stall_o  (sleep_stall)
  );

  // Merge and register, this is the only state in the controller
  stall_merge u_stall_merge (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .jalr_sel_i     (jalr_sel),
    .load_stall_i   (load_stall),
    .jalr_stall_i   (jalr_stall),
    .csr_stall_id_i (csr_stall_id),
    .csr_stall_ex_i (csr_stall_ex),
    .sleep_stall_i  (sleep_stall),
    .op_a_sel_o     (op_a_sel_o),
    .op_b_sel_o     (op_b_sel_o),
    .jalr_sel_o     (jalr_sel_o),
    .load_stall_o   (load_stall_o),
    .jalr_stall_o   (jalr_stall_o),
    .csr_stall_id_o (csr_stall_id_o),
    .csr_stall_ex_o (csr_stall_ex_o),
    .sleep_stall_o  (sleep_stall_o),
    .stall_id_o     (stall_id_o),
    .stall_ex_o     (stall_ex_o)
  );

endmodule

`default_nettype wire

//--- tb/bypass_ctrl_sva.sv
// Bypass controller assertions
// Checks stall ordering, the EX forward source and the reset values
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl_sva (
  input  wire logic                      clk,
  input  wire logic                      rst_n_i,
  input  wire logic                      ex_valid_i,
  input  wire logic                      ex_rf_we_i,
  input  wire byp_pipe_pkg::op_fw_sel_e  op_a_sel_o,
  input  wire logic                      load_stall_o,
  input  wire logic                      jalr_stall_o,
  input  wire logic                      csr_stall_id_o,
  input  wire logic                      csr_stall_ex_o,
  input  wire logic                      sleep_stall_o,
  input  wire logic                      stall_id_o,
  input  wire logic                      stall_ex_o
);

  // Number of failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // A held EX always holds ID as well
  stall_ex_holds_id: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_ex_o |-> stall_id_o)
    else begin
      fail_count++;
      $error("stall_ex_o set while stall_id_o is clear");
    end

  // The EX forward needs a valid EX write one cycle before the output
  fw_ex_needs_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    (op_a_sel_o == byp_pipe_pkg::SEL_FW_EX) |-> $past(ex_valid_i && ex_rf_we_i))
    else begin
      fail_count++;
      $error("op_a_sel_o selects EX without a valid EX write");
    end

  // No stall may leave the controller during reset
  reset_clears_stalls: assert property (@(posedge clk)
    !rst_n_i |-> !(load_stall_o || jalr_stall_o || csr_stall_id_o || csr_stall_ex_o ||
                   sleep_stall_o || stall_id_o || stall_ex_o))
    else begin
      fail_count++;
      $error("stall output set while reset is low");
    end

endmodule

bind bypass_ctrl bypass_ctrl_sva u_sva (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .ex_valid_i     (ex_valid_i),
  .ex_rf_we_i     (ex_rf_we_i),
  .op_a_sel_o     (op_a_sel_o),
  .load_stall_o   (load_stall_o),
  .jalr_stall_o   (jalr_stall_o),
  .csr_stall_id_o (csr_stall_id_o),
  .csr_stall_ex_o (csr_stall_ex_o),
  .sleep_stall_o  (sleep_stall_o),
  .stall_id_o     (stall_id_o),
  .stall_ex_o     (stall_ex_o)
);

`default_nettype wire

//--- tb/bypass_ctrl_tb.sv
// Bypass controller testbench
// Applies a table of pipeline states and checks the registered selects
// and stalls one cycle after each row
`timescale 1ns/1ps
`default_nettype none

`include "byp_consts.svh"

module bypass_ctrl_tb;

  localparam int RESET_TIMEOUT = 16;

  // One table row with the groups packed in port order
  // id  {valid, re[1:0], raddr_a, raddr_b, jalr, mret}
  // ex  {valid, rf_we, waddr, lsu_en, csr_en, mret, wfi}
  // wb  {valid, rf_we, waddr, lsu_en, csr_en, mret, ready}
  // csr {re, raddr, we, waddr}
  // exp {op_a_sel, op_b_sel, jalr_sel, load, jalr, csr_id, csr_ex, sleep, stall_id, stall_ex}
  // dc[0] randomizes the register addresses, dc[1] the CSR addresses
  typedef struct {
    string        name;
    logic [1:0]   dc;
    logic [14:0]  id;
    logic [10:0]  ex;
    logic [10:0]  wb;
    logic [25:0]  csr;
    logic [11:0]  exp;
  } row_t;

  logic                             clk;
  logic                             rst_n_i;
  logic                             id_valid_i;
  logic [`BYP_NUM_READ_PORTS-1:0]   rf_re_id_i;
  byp_pipe_pkg::reg_addr_t          rf_raddr_a_id_i;
  byp_pipe_pkg::reg_addr_t          rf_raddr_b_id_i;
  logic                             jalr_id_i;
  logic                             mret_id_i;
  logic                             ex_valid_i;
  logic                             ex_rf_we_i;
  byp_pipe_pkg::reg_addr_t          ex_rf_waddr_i;
  logic                             ex_lsu_en_i;
  logic                             ex_csr_en_i;
  logic                             ex_mret_i;
  logic                             ex_wfi_i;
  logic                             wb_valid_i;
  logic                             wb_rf_we_i;
  byp_pipe_pkg::reg_addr_t          wb_rf_waddr_i;
  logic                             wb_lsu_en_i;
  logic                             wb_csr_en_i;
  logic                             wb_mret_i;
  logic                             wb_ready_i;
  logic                             csr_re_ex_i;
  byp_csr_pkg::csr_addr_t           csr_raddr_ex_i;
  logic                             csr_we_wb_i;
  byp_csr_pkg::csr_addr_t           csr_waddr_wb_i;
  byp_pipe_pkg::op_fw_sel_e         op_a_sel_o;
  byp_pipe_pkg::op_fw_sel_e         op_b_sel_o;
  byp_pipe_pkg::jalr_fw_sel_e       jalr_sel_o;
  logic                             load_stall_o;
  logic                             jalr_stall_o;
  logic                             csr_stall_id_o;
  logic                             csr_stall_ex_o;
  logic                             sleep_stall_o;
  logic                             stall_id_o;
  logic                             stall_ex_o;

  row_t rows[$];
  int   check_count = 0;
  int   error_count = 0;

  bypass_ctrl DUT (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [1:0] dc, input logic [14:0] id,
                         input logic [10:0] ex, input logic [10:0] wb,
                         input logic [25:0] csr, input logic [11:0] exp);
    row_t r;
    r.name = name;
    r.dc   = dc;
    r.id   = id;
    r.ex   = ex;
    r.wb   = wb;
    r.csr  = csr;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  // Drives one row right after a rising edge
  task automatic apply_row(input row_t r);
    logic [14:0] id;
    logic [10:0] ex;
    logic [10:0] wb;
    logic [25:0] csr;
    id  = r.id;
    ex  = r.ex;
    wb  = r.wb;
    csr = r.csr;
    // Addresses marked as don't care must not change any result
    if (r.dc[0]) begin
      id[11:7] = 5'($urandom);
      id[6:2]  = 5'($urandom);
      ex[8:4]  = 5'($urandom);
      wb[8:4]  = 5'($urandom);
    end
    if (r.dc[1]) begin
      csr[24:13] = 12'($urandom);
      csr[11:0]  = 12'($urandom);
    end
    {id_valid_i, rf_re_id_i, rf_raddr_a_id_i, rf_raddr_b_id_i, jalr_id_i, mret_id_i} <= id;
    {ex_valid_i, ex_rf_we_i, ex_rf_waddr_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i,
     ex_wfi_i} <= ex;
    {wb_valid_i, wb_rf_we_i, wb_rf_waddr_i, wb_lsu_en_i, wb_csr_en_i, wb_mret_i,
     wb_ready_i} <= wb;
    {csr_re_ex_i, csr_raddr_ex_i, csr_we_wb_i, csr_waddr_wb_i} <= csr;
  endtask

  task automatic set_reset(input logic value);
    rst_n_i <= value;
  endtask

  task automatic check_outputs(input logic [11:0] exp, input string tag);
    logic [11:0] got;
    got = {op_a_sel_o, op_b_sel_o, jalr_sel_o, load_stall_o, jalr_stall_o,
           csr_stall_id_o, csr_stall_ex_o, sleep_stall_o, stall_id_o, stall_ex_o};
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, tag, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic build_table();
    add_row("idle", 2'b11,
            15'b0_00_00000_00000_0_0, 11'b0_0_00000_0_0_0_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_0_0_0_0_0);
    add_row("EX forward on both ports", 2'b10,
            15'b1_11_00011_00011_0_0, 11'b1_1_00011_0_0_0_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b01_01_0_0_0_0_0_0_0_0);
    add_row("WB forward on port B", 2'b10,
            15'b1_11_00101_00111_0_0, 11'b1_1_01001_0_0_0_0, 11'b1_1_00111_0_0_0_1,
            26'd0, 12'b00_10_0_0_0_0_0_0_0_0);
    // Both stages write x4 and the younger EX result wins
    add_row("EX over WB", 2'b10,
            15'b1_11_00100_00100_0_0, 11'b1_1_00100_0_0_0_0, 11'b1_1_00100_0_0_0_1,
            26'd0, 12'b01_01_1_0_0_0_0_0_0_0);
    add_row("x0 never forwards", 2'b10,
            15'b1_11_00000_00000_0_0, 11'b1_1_00000_0_0_0_0, 11'b1_1_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_0_0_0_0_0);
    // jalr select still follows the WB write of rs1
    add_row("read enables clear", 2'b10,
            15'b1_00_00110_00110_0_0, 11'b1_1_00110_0_0_0_0, 11'b1_1_00110_0_0_0_1,
            26'd0, 12'b00_00_1_0_0_0_0_0_0_0);
    add_row("load in EX", 2'b10,
            15'b1_01_01000_00010_0_0, 11'b1_1_01000_1_0_0_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b01_00_0_1_0_0_0_0_1_0);
    add_row("WB match with ready low", 2'b10,
            15'b1_11_01010_01011_0_0, 11'b0_0_00000_0_0_0_0, 11'b1_1_01011_1_0_0_0,
            26'd0, 12'b00_10_0_1_0_0_0_0_1_0);
    add_row("WB match with ready high", 2'b10,
            15'b1_11_01010_01011_0_0, 11'b0_0_00000_0_0_0_0, 11'b1_1_01011_1_0_0_1,
            26'd0, 12'b00_10_0_0_0_0_0_0_0_0);
    add_row("jalr against EX write", 2'b10,
            15'b1_01_01100_00000_1_0, 11'b1_1_01100_0_0_0_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b01_00_0_0_1_0_0_0_1_0);
    add_row("jalr against WB ALU write", 2'b10,
            15'b1_01_01101_00000_1_0, 11'b0_0_00000_0_0_0_0, 11'b1_1_01101_0_0_0_1,
            26'd0, 12'b10_00_1_0_0_0_0_0_0_0);
    add_row("jalr against WB load", 2'b10,
            15'b1_01_01101_00000_1_0, 11'b0_0_00000_0_0_0_0, 11'b1_1_01101_1_0_0_1,
            26'd0, 12'b10_00_1_0_1_0_0_0_1_0);
    add_row("mret in ID, CSR write in EX", 2'b11,
            15'b1_00_00000_00000_0_1, 11'b1_0_00000_0_1_0_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_1_0_0_1_0);
    add_row("mret in ID, mret in EX", 2'b11,
            15'b1_00_00000_00000_0_1, 11'b1_0_00000_0_0_1_0, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_1_0_0_1_0);
    add_row("mret in ID, CSR write in WB", 2'b11,
            15'b1_00_00000_00000_0_1, 11'b0_0_00000_0_0_0_0, 11'b1_0_00000_0_1_0_1,
            26'd0, 12'b00_00_0_0_0_1_0_0_1_0);
    add_row("mret in ID, mret in WB", 2'b11,
            15'b1_00_00000_00000_0_1, 11'b0_0_00000_0_0_0_0, 11'b1_0_00000_0_0_1_1,
            26'd0, 12'b00_00_0_0_0_1_0_0_1_0);
    add_row("CSR read after write, same address", 2'b01,
            15'b0_00_00000_00000_0_0, 11'b1_0_00000_0_1_0_0, 11'b1_0_00000_0_1_0_1,
            {1'b1, 12'h300, 1'b1, 12'h300}, 12'b00_00_0_0_0_0_1_0_1_1);
    add_row("CSR read after write, other address", 2'b01,
            15'b0_00_00000_00000_0_0, 11'b1_0_00000_0_1_0_0, 11'b1_0_00000_0_1_0_1,
            {1'b1, 12'h300, 1'b1, 12'h341}, 12'b00_00_0_0_0_0_0_0_0_0);
    add_row("CSR op in EX, mret in WB", 2'b11,
            15'b0_00_00000_00000_0_0, 11'b1_0_00000_0_1_0_0, 11'b1_0_00000_0_0_1_1,
            {1'b1, 12'h000, 1'b0, 12'h000}, 12'b00_00_0_0_0_0_1_0_1_1);
    add_row("WFI in EX", 2'b11,
            15'b0_00_00000_00000_0_0, 11'b1_0_00000_0_0_0_1, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_0_0_1_1_0);
    // An invalid EX must be ignored even with every flag set
    add_row("invalid EX ignored", 2'b10,
            15'b1_01_00011_00000_0_0, 11'b0_1_00011_1_0_0_1, 11'b0_0_00000_0_0_0_1,
            26'd0, 12'b00_00_0_0_0_0_0_0_0_0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          wait_cycles;
    int unsigned sva_failures;
    void'($urandom(32'h097ddeb5));
    // Start high so that the asynchronous reset sees a real falling edge
    rst_n_i = 1'b1;
    {id_valid_i, rf_re_id_i, rf_raddr_a_id_i, rf_raddr_b_id_i, jalr_id_i, mret_id_i} = '0;
    {ex_valid_i, ex_rf_we_i, ex_rf_waddr_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i, ex_wfi_i} = '0;
    {wb_valid_i, wb_rf_we_i, wb_rf_waddr_i, wb_lsu_en_i, wb_csr_en_i, wb_mret_i} = '0;
    wb_ready_i = 1'b1;
    {csr_re_ex_i, csr_raddr_ex_i, csr_we_wb_i, csr_waddr_wb_i} = '0;
    build_table();

    @(posedge clk);
    set_reset(1'b0);
    repeat (3) @(posedge clk);
    #1;
    check_outputs(12'd0, "during reset");
    @(posedge clk);
    set_reset(1'b1);

    wait_cycles = 0;
    while (rst_n_i !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end

    if (rst_n_i !== 1'b1) begin
      error_count++;
      $display("reset release was not seen within %0d cycles", RESET_TIMEOUT);
    end else begin
      #1;
      check_outputs(12'd0, "after reset");
      // Each row is held for two edges and checked after the second one
      foreach (rows[i]) begin
        @(posedge clk);
        apply_row(rows[i]);
        @(posedge clk);
        #1;
        check_outputs(rows[i].exp, rows[i].name);
      end
    end

    sva_failures = DUT.u_sva.fail_count;
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, sva_failures);
    if (error_count == 0 && sva_failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/byp_pipe_pkg.sv
common/byp_csr_pkg.sv
bypass/operand_hazard_unit.sv
bypass/csr_hazard_unit.sv
bypass/stall_merge.sv
rtl/bypass_ctrl.sv
tb/bypass_ctrl_sva.sv
tb/bypass_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bypass controller testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR="obj_dir"
SIM_BIN="bypass_ctrl_sim"
LOG_FILE="sim.log"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module bypass_ctrl_tb \
  -Mdir "${BUILD_DIR}" \
  -o "${SIM_BIN}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

# Keep running after an assertion error so the testbench can summarize
"./${BUILD_DIR}/${SIM_BIN}" +verilator+error+limit+100 > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"

if grep -q "TESTBENCH FAILED" "${LOG_FILE}"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ ${run_status} -ne 0 ]; then
  echo "Simulation exited with status ${run_status}"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "${LOG_FILE}"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
